// File: hdl/mem_pkg.sv
package mem_pkg;

  // data ram geometry
  localparam int ram_words      = 256;
  localparam int ram_index_bits = 8;   // word index from addr[9:2], upper bits alias

  // memory opcodes, op_none doubles as the squash code
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_lbu  = 4'd4,
    op_lhu  = 4'd5,
    op_sb   = 4'd6,
    op_sh   = 4'd7,
    op_sw   = 4'd8
  } mem_op_e;

  // external command, 74 bits
  typedef struct packed {
    logic        valid;
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [4:0]  rd;
  } mem_cmd_t;

  // registered producer output, 75 bits
  typedef struct packed {
    logic        valid;
    mem_op_e     op;     // op_none when squashed
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [4:0]  rd;
    logic        fault;  // misaligned access
  } exec_result_t;

  // registered access result, 40 bits
  typedef struct packed {
    logic        valid;
    logic        is_load;
    logic        fault;
    logic [4:0]  rd;
    logic [31:0] rd_data;
  } mem_result_t;

endpackage

// File: hdl/address_unit.sv
`timescale 1ns/1ps

module address_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  mem_pkg::mem_cmd_t      cmd,
  output mem_pkg::exec_result_t  exec
);

  logic cmd_live;     // valid command carrying a real opcode
  logic half_access;
  logic word_access;
  logic misaligned;

  assign cmd_live = cmd.valid && (cmd.op != mem_pkg::op_none);

  // access width from the opcode
  always_comb begin
    half_access = 1'b0;
    word_access = 1'b0;
    case (cmd.op)
      mem_pkg::op_lh,
      mem_pkg::op_lhu,
      mem_pkg::op_sh: half_access = 1'b1;
      mem_pkg::op_lw,
      mem_pkg::op_sw: word_access = 1'b1;
      default: ;
    endcase
  end

  // bytes never fault
  assign misaligned = (half_access && cmd.addr[0]) ||
                      (word_access && (cmd.addr[1:0] != 2'b00));

  // control fields
  always_ff @(posedge clk) begin
    if (reset) begin
      exec.valid <= 1'b0;
      exec.op    <= mem_pkg::op_none;
      exec.fault <= 1'b0;
    end else begin
      exec.valid <= cmd_live;
      exec.fault <= cmd_live && misaligned;
      // squash faulting or idle commands so nothing is stored or written back
      if (cmd_live && !misaligned) begin
        exec.op <= cmd.op;
      end else begin
        exec.op <= mem_pkg::op_none;
      end
    end
  end

  // payload just follows the command
  always_ff @(posedge clk) begin
    exec.addr  <= cmd.addr;
    exec.wdata <= cmd.wdata;
    exec.rd    <= cmd.rd;
  end

endmodule

// File: hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic        clk,
  input  logic [31:0] mem_addr,
  input  logic [3:0]  mem_wstrb,
  input  logic [31:0] mem_wdata,
  output logic [31:0] mem_rdata
);

  logic [31:0] mem [mem_pkg::ram_words];
  logic [mem_pkg::ram_index_bits-1:0] word_index;

  // word index, byte offset and upper bits ignored
  assign word_index = mem_addr[mem_pkg::ram_index_bits+1:2];

  // asynchronous read
  assign mem_rdata = mem[word_index];

  // byte-lane writes
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (mem_wstrb[lane]) begin
        mem[word_index][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
      end
    end
  end

endmodule

// File: hdl/mem_access.sv
`timescale 1ns/1ps

module mem_access (
  input  logic                   clk,
  input  logic                   reset,
  input  mem_pkg::exec_result_t  exec,
  output logic [31:0]            mem_addr,
  output logic [3:0]             mem_wstrb,
  output logic [31:0]            mem_wdata,
  input  logic [31:0]            mem_rdata,
  output mem_pkg::mem_result_t   result
);

  logic        is_load;
  logic [7:0]  load_byte;
  logic [15:0] load_half;
  logic [31:0] load_data;

  // request always goes to the aligned word
  assign mem_addr = {exec.addr[31:2], 2'b00};

  // strobes and lane replication
  always_comb begin
    mem_wstrb = 4'b0000;
    mem_wdata = exec.wdata;
    if (exec.valid) begin
      case (exec.op)
        mem_pkg::op_sw: begin
          mem_wstrb = 4'b1111;
        end
        mem_pkg::op_sh: begin
          mem_wstrb = exec.addr[1] ? 4'b1100 : 4'b0011;
          mem_wdata = {2{exec.wdata[15:0]}};
        end
        mem_pkg::op_sb: begin
          mem_wstrb = 4'b0001 << exec.addr[1:0];
          mem_wdata = {4{exec.wdata[7:0]}};
        end
        default: ; // loads and op_none write nothing
      endcase
    end
  end

  always_comb begin
    case (exec.op)
      mem_pkg::op_lb,
      mem_pkg::op_lh,
      mem_pkg::op_lw,
      mem_pkg::op_lbu,
      mem_pkg::op_lhu: is_load = 1'b1;
      default:         is_load = 1'b0;
    endcase
  end

  // pick the addressed byte
  always_comb begin
    case (exec.addr[1:0])
      2'b00:   load_byte = mem_rdata[7:0];
      2'b01:   load_byte = mem_rdata[15:8];
      2'b10:   load_byte = mem_rdata[23:16];
      default: load_byte = mem_rdata[31:24];
    endcase
  end

  assign load_half = exec.addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  // extend to 32 bits, zero for stores and squashed ops
  always_comb begin
    case (exec.op)
      mem_pkg::op_lb:  load_data = {{24{load_byte[7]}}, load_byte};
      mem_pkg::op_lbu: load_data = {24'b0, load_byte};
      mem_pkg::op_lh:  load_data = {{16{load_half[15]}}, load_half};
      mem_pkg::op_lhu: load_data = {16'b0, load_half};
      mem_pkg::op_lw:  load_data = mem_rdata;
      default:         load_data = 32'b0;
    endcase
  end

  // registered response, control fields
  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid   <= 1'b0;
      result.is_load <= 1'b0;
      result.fault   <= 1'b0;
    end else begin
      result.valid   <= exec.valid;
      result.is_load <= exec.valid && is_load;
      result.fault   <= exec.valid && exec.fault;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    result.rd      <= exec.rd;
    result.rd_data <= (exec.valid && !exec.fault) ? load_data : 32'b0;
  end

endmodule

// File: hdl/reg_writeback.sv
`timescale 1ns/1ps

module reg_writeback (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_pkg::mem_result_t  result,
  input  logic [4:0]            rs_addr,
  output logic [31:0]           rs_data
);

  logic [31:0] regs [32];
  logic        wr_en;

  // only clean loads to a real register
  assign wr_en = result.valid && result.is_load && !result.fault &&
                 (result.rd != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (wr_en) begin
      regs[result.rd] <= result.rd_data;
    end
  end

  // inspection port, x0 hardwired
  assign rs_data = (rs_addr == 5'd0) ? 32'b0 : regs[rs_addr];

endmodule

// File: hdl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_pkg::mem_cmd_t     cmd,
  output mem_pkg::mem_result_t  result,
  input  logic [4:0]            rs_addr,
  output logic [31:0]           rs_data
);

  mem_pkg::exec_result_t exec;

  // ram bus
  logic [31:0] mem_addr;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  address_unit u_address_unit (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd),
    .exec  (exec)
  );

  mem_access u_mem_access (
    .clk       (clk),
    .reset     (reset),
    .exec      (exec),
    .mem_addr  (mem_addr),
    .mem_wstrb (mem_wstrb),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .result    (result)
  );

  data_ram u_data_ram (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_wstrb (mem_wstrb),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  // result also feeds the top-level output
  reg_writeback u_reg_writeback (
    .clk     (clk),
    .reset   (reset),
    .result  (result),
    .rs_addr (rs_addr),
    .rs_data (rs_data)
  );

endmodule

// File: verification/mem_subsystem_sva.sv
`timescale 1ns/1ps

module mem_subsystem_sva (
  input logic                  clk,
  input logic                  reset,
  input mem_pkg::exec_result_t exec,
  input logic [3:0]            mem_wstrb,
  input mem_pkg::mem_result_t  result
);

  logic exec_is_store;

  assign exec_is_store = exec.valid &&
                         ((exec.op == mem_pkg::op_sb) ||
                          (exec.op == mem_pkg::op_sh) ||
                          (exec.op == mem_pkg::op_sw));

  // loads, squashed ops and idle cycles leave the ram alone
  no_stray_strobe: assert property (@(posedge clk) disable iff (reset)
    !exec_is_store |-> (mem_wstrb == 4'b0000))
    else $error("byte strobes active without a store in exec");

  // fixed one-cycle latency through the access block
  valid_follows_exec: assert property (@(posedge clk) disable iff (reset)
    result.valid == $past(exec.valid))
    else $error("result.valid does not follow exec.valid by one cycle");

  fault_has_no_data: assert property (@(posedge clk) disable iff (reset)
    (result.valid && result.fault) |-> (result.rd_data == 32'b0))
    else $error("faulting result carries nonzero rd_data");

  // no result straight out of reset
  reset_clears_valid: assert property (@(posedge clk)
    reset |=> !result.valid)
    else $error("result.valid high in the cycle after reset");

endmodule

bind mem_access mem_subsystem_sva u_mem_subsystem_sva (
  .clk       (clk),
  .reset     (reset),
  .exec      (exec),
  .mem_wstrb (mem_wstrb),
  .result    (result)
);

// File: verification/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

  localparam int clk_period      = 20;
  localparam int reset_cycles    = 8;
  localparam int random_cmds     = 2000;
  localparam int directed_cmds   = 250;  // upper bound on directed steps
  localparam int watchdog_cycles = reset_cycles + random_cmds + directed_cmds + 50;

  logic                 clk;
  logic                 reset;
  mem_pkg::mem_cmd_t    cmd;
  mem_pkg::mem_result_t result;
  logic [4:0]           rs_addr;
  logic [31:0]          rs_data;

  logic [7:0]           ram_image [1024];   // byte image that aliases on addr[9:0] like the dut
  logic [31:0]          model_regs [32];
  mem_pkg::mem_result_t pending [$];        // predictions two cycles deep
  string                test_name;

  mem_subsystem_top UUT (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .result  (result),
    .rs_addr (rs_addr),
    .rs_data (rs_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // one cycle per step so the step count bounds the whole run
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: no end of test after %0d clock cycles", watchdog_cycles);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic int op_size(input mem_pkg::mem_op_e op);
    case (op)
      mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: return 1;
      mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: return 2;
      mem_pkg::op_lw, mem_pkg::op_sw:                  return 4;
      default:                                         return 0;
    endcase
  endfunction

  function automatic logic is_load_op(input mem_pkg::mem_op_e op);
    return (op == mem_pkg::op_lb) || (op == mem_pkg::op_lh) || (op == mem_pkg::op_lw) ||
           (op == mem_pkg::op_lbu) || (op == mem_pkg::op_lhu);
  endfunction

  function automatic mem_pkg::mem_cmd_t make_cmd(input mem_pkg::mem_op_e op,
                                                 input logic [31:0] addr,
                                                 input logic [31:0] wdata,
                                                 input logic [4:0] rd);
    mem_pkg::mem_cmd_t c;
    c.valid = 1'b1;
    c.op    = op;
    c.addr  = addr;
    c.wdata = wdata;
    c.rd    = rd;
    return c;
  endfunction

  // 64-word window at addr[7:2] with random upper bits to hit the aliasing
  function automatic logic [31:0] random_addr(input int size);
    logic [31:0] upper;
    logic [31:0] offset;
    logic [31:0] addr;
    upper  = $urandom;
    offset = $urandom;
    addr   = {upper[31:10], 2'b00, offset[7:2], 2'b00};
    if (($urandom % 10) == 0) begin
      addr[1:0] = offset[1:0];  // deliberate fault for wider ops
    end else if (size == 1) begin
      addr[1:0] = offset[1:0];
    end else if (size == 2) begin
      addr[1] = offset[1];
    end
    return addr;
  endfunction

  function automatic mem_pkg::mem_cmd_t random_cmd();
    mem_pkg::mem_cmd_t c;
    int unsigned       pick;
    c = '0;
    if (($urandom % 100) >= 20) begin  // otherwise idle
      pick    = $urandom % 8;
      c.valid = 1'b1;
      c.op    = mem_pkg::mem_op_e'(4'(pick + 1));
      c.addr  = random_addr(op_size(c.op));
      c.wdata = $urandom;
      c.rd    = 5'($urandom);
    end
    return c;
  endfunction

  // reference model updating the byte image in command order
  task automatic predict(input mem_pkg::mem_cmd_t c, output mem_pkg::mem_result_t p);
    int          size;
    logic        fault;
    logic [9:0]  base;
    logic [31:0] raw;
    p    = '0;
    size = op_size(c.op);
    if (c.valid && (c.op != mem_pkg::op_none)) begin
      base      = c.addr[9:0];
      fault     = ((size == 2) && c.addr[0]) || ((size == 4) && (c.addr[1:0] != 2'b00));
      p.valid   = 1'b1;
      p.fault   = fault;
      p.rd      = c.rd;
      p.is_load = is_load_op(c.op) && !fault;  // squashed loads lose their op
      if (!fault && p.is_load) begin
        raw = '0;
        for (int i = 0; i < size; i++) begin
          raw[i*8 +: 8] = ram_image[base + 10'(i)];
        end
        case (c.op)
          mem_pkg::op_lb: p.rd_data = {{24{raw[7]}}, raw[7:0]};
          mem_pkg::op_lh: p.rd_data = {{16{raw[15]}}, raw[15:0]};
          default:        p.rd_data = raw;  // unsigned and word loads keep zero upper bytes
        endcase
      end else if (!fault) begin
        for (int i = 0; i < size; i++) begin
          ram_image[base + 10'(i)] = c.wdata[i*8 +: 8];
        end
      end
    end
  endtask

  task automatic compare_result(input mem_pkg::mem_result_t exp_res);
    check_value({test_name, " result.valid"}, 32'(exp_res.valid), 32'(result.valid));
    if (exp_res.valid) begin
      check_value({test_name, " result.is_load"}, 32'(exp_res.is_load), 32'(result.is_load));
      check_value({test_name, " result.fault"}, 32'(exp_res.fault), 32'(result.fault));
      check_value({test_name, " result.rd"}, 32'(exp_res.rd), 32'(result.rd));
      check_value({test_name, " result.rd_data"}, exp_res.rd_data, result.rd_data);
    end
  endtask

  // one clock of checking outputs, retiring the oldest prediction and driving the next inputs
  task automatic step(input mem_pkg::mem_cmd_t c, input logic [4:0] rs_next);
    mem_pkg::mem_result_t exp_res;
    mem_pkg::mem_result_t new_res;
    @(negedge clk);
    check_value($sformatf("%s rs_data x%0d", test_name, rs_addr),
                model_regs[rs_addr], rs_data);
    exp_res = pending.pop_front();
    compare_result(exp_res);
    if (exp_res.valid && exp_res.is_load && !exp_res.fault && (exp_res.rd != 5'd0)) begin
      model_regs[exp_res.rd] = exp_res.rd_data;  // lands at the next edge
    end
    predict(c, new_res);
    pending.push_back(new_res);
    cmd     = c;
    rs_addr = rs_next;
  endtask

  initial begin
    mem_pkg::mem_cmd_t idle;
    logic [31:0]       base;
    void'($urandom(32'heec8));
    idle       = '0;
    reset      = 1'b1;
    cmd        = '0;
    rs_addr    = 5'd0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'b0;
    end
    for (int i = 0; i < 1024; i++) begin
      ram_image[i] = 8'h00;
    end
    pending.push_back('0);
    pending.push_back('0);
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    test_name = "reset";
    for (int i = 0; i < 32; i++) begin
      step(idle, 5'(i));
    end

    // fill the whole window so no load sees uninitialised ram
    test_name = "word_store_load";
    for (int w = 0; w < 64; w++) begin
      step(make_cmd(mem_pkg::op_sw, 32'(w * 4), $urandom, 5'd0), 5'd0);
    end
    for (int k = 1; k <= 8; k++) begin
      step(make_cmd(mem_pkg::op_lw, 32'(($urandom % 64) * 4), 32'b0, 5'(k)), 5'd0);
    end
    step(make_cmd(mem_pkg::op_sw, 32'd16, 32'hcafe_f00d, 5'd0), 5'd0);
    step(make_cmd(mem_pkg::op_lw, 32'd16, 32'b0, 5'd9), 5'd0);  // back to back
    for (int k = 1; k <= 9; k++) begin
      step(idle, 5'(k));
    end

    test_name = "narrow_stores";
    for (int off = 0; off < 4; off++) begin
      step(make_cmd(mem_pkg::op_sb, 32'(20 + off), $urandom, 5'd0), 5'd0);
      step(make_cmd(mem_pkg::op_lw, 32'd20, 32'b0, 5'd9), 5'd9);
    end
    for (int off = 0; off < 4; off += 2) begin
      step(make_cmd(mem_pkg::op_sh, 32'(20 + off), $urandom, 5'd0), 5'd0);
      step(make_cmd(mem_pkg::op_lw, 32'd20, 32'b0, 5'd9), 5'd9);
    end

    test_name = "load_extend";
    step(make_cmd(mem_pkg::op_sw, 32'd24, 32'h81ff_7f80, 5'd0), 5'd0);  // both sign polarities
    for (int off = 0; off < 4; off++) begin
      step(make_cmd(mem_pkg::op_lb, 32'(24 + off), 32'b0, 5'd10), 5'd10);
      step(make_cmd(mem_pkg::op_lbu, 32'(24 + off), 32'b0, 5'd11), 5'd11);
    end
    for (int off = 0; off < 4; off += 2) begin
      step(make_cmd(mem_pkg::op_lh, 32'(24 + off), 32'b0, 5'd12), 5'd12);
      step(make_cmd(mem_pkg::op_lhu, 32'(24 + off), 32'b0, 5'd13), 5'd13);
    end

    test_name = "misaligned";
    base = 32'd28;
    step(make_cmd(mem_pkg::op_sw, base, 32'h1234_5678, 5'd0), 5'd0);
    for (int off = 1; off < 4; off++) begin
      step(make_cmd(mem_pkg::op_lw, base + 32'(off), 32'b0, 5'd14), 5'd14);
      step(make_cmd(mem_pkg::op_sw, base + 32'(off), $urandom, 5'd0), 5'd14);
    end
    for (int off = 1; off < 4; off += 2) begin
      step(make_cmd(mem_pkg::op_lh, base + 32'(off), 32'b0, 5'd14), 5'd14);
      step(make_cmd(mem_pkg::op_sh, base + 32'(off), $urandom, 5'd0), 5'd14);
    end
    step(make_cmd(mem_pkg::op_lw, base, 32'b0, 5'd15), 5'd14);
    step(idle, 5'd15);

    test_name = "x0_load";
    step(make_cmd(mem_pkg::op_lw, base, 32'b0, 5'd0), 5'd0);
    repeat (3) step(idle, 5'd0);

    test_name = "random_mix";
    for (int n = 0; n < random_cmds; n++) begin
      step(random_cmd(), 5'($urandom));
    end
    repeat (3) step(idle, 5'($urandom));  // drain the last predictions

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: build.f
hdl/mem_pkg.sv
hdl/address_unit.sv
hdl/data_ram.sv
hdl/mem_access.sv
hdl/reg_writeback.sv
hdl/mem_subsystem_top.sv
verification/mem_subsystem_sva.sv
verification/mem_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator and run, pass only if the pass message shows up
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module mem_subsystem_tb -f build.f &&
  ./obj_dir/Vmem_subsystem_tb | tee /dev/stderr |
    grep -q "Simulation completed successfully" &&
  echo "run_sim: passed" ||
  { echo "run_sim: failed"; exit 1; }
